//--- filelist.f
hdl/gf128_pkg.sv
hdl/ghash_ctrl_pkg.sv
hdl/gf_mult_if.sv
hdl/gf_2to128_multiplier_booth1_subrem.sv
hdl/gf_2to128_digit_product.sv
hdl/gf_2to128_multiplier_digit_serial.sv
hdl/ghash_core.sv
hdl/ghash_top.sv
tests/ghash_asserts.sv
tests/tb_ghash_top.sv

//--- Bender.yml
package:
  name: ghash

sources:
  - hdl/gf128_pkg.sv
  - hdl/ghash_ctrl_pkg.sv
  - hdl/gf_mult_if.sv
  - hdl/gf_2to128_multiplier_booth1_subrem.sv
  - hdl/gf_2to128_digit_product.sv
  - hdl/gf_2to128_multiplier_digit_serial.sv
  - hdl/ghash_core.sv
  - hdl/ghash_top.sv
  - target: test
    files:
      - tests/ghash_asserts.sv
      - tests/tb_ghash_top.sv

//--- tests/tb_ghash_top.sv
// Directed testbench for the GHASH engine, checked against a bitwise GCM reference multiply.
`timescale 1ns/1ps

module tb_ghash_top;

    // Tag is seen by this edge after acceptance: start, multiply, commit.
    localparam int TAG_LATENCY = ghash_ctrl_pkg::MULT_LATENCY + 2;
    localparam int TAG_WAIT = 25;
    // Blocks over all tests, including the one cut by reset.
    localparam int TOTAL_BLOCKS = 22;
    localparam int TIMEOUT_CYCLES = TOTAL_BLOCKS * TAG_WAIT + 200;

    logic clock = 1'b0;
    logic rst, clear, key_load, block_valid, busy, tag_valid;
    gf128_pkg::gf128_t key, block, tag;
    // Mirror of Y and H.
    gf128_pkg::gf128_t model_y, model_h;
    logic [31:0] rng_state = 32'd51;
    int errors = 0;
    int cycles = 0;

    ghash_top u_dut (.*);

    always #4 clock = ~clock;

    // Run limit.
    always @(posedge clock)
    begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // GCM shift-and-reduce, one bit of x per pass.
    // Vector bit 127 is x^0, so times x is a right shift.
    function automatic gf128_pkg::gf128_t gf_mult_ref(gf128_pkg::gf128_t x,
                                                      gf128_pkg::gf128_t y);
        gf128_pkg::gf128_t z;
        gf128_pkg::gf128_t v;
        z = '0;
        v = y;
        for (int i = 0; i < 128; i++)
        begin
            if (x[127-i])
                z = z ^ v;
            // x^127 falls off, fold with R.
            v = v[0] ? ((v >> 1) ^ {8'he1, 120'h0}) : (v >> 1);
        end
        return z;
    endfunction

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Four words, first one ends up on top.
    function automatic gf128_pkg::gf128_t rand_block();
        gf128_pkg::gf128_t r;
        for (int w = 0; w < 4; w++)
            r = {r[95:0], xorshift32()};
        return r;
    endfunction

    // Inputs change 1 ns after the edge.
    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_tag(string name, gf128_pkg::gf128_t got, gf128_pkg::gf128_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_timing(int got);
        if (got != TAG_LATENCY)
        begin
            errors++;
            $display("mismatch at %0t: tag latency got %0d expected %0d", $time, got, TAG_LATENCY);
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (4) next_cycle();
        rst = 1'b0;
        model_y = '0;
        model_h = '0;
    endtask

    task automatic load_key(gf128_pkg::gf128_t k);
        key_load = 1'b1;
        key = k;
        next_cycle();
        key_load = 1'b0;
        model_h = k;
    endtask

    task automatic clear_hash();
        clear = 1'b1;
        next_cycle();
        clear = 1'b0;
        model_y = '0;
        check_tag("tag", tag, '0);
    endtask

    // One block through the engine, tag and latency checked against the mirror.
    // With disturb, all strobes pulse mid-multiply and must be dropped.
    task automatic absorb_block(gf128_pkg::gf128_t x, bit disturb);
        gf128_pkg::gf128_t expected;
        int edges;
        expected = gf_mult_ref(model_y ^ x, model_h);
        block = x;
        block_valid = 1'b1;
        next_cycle();
        block_valid = 1'b0;
        edges = 0;
        while (!tag_valid && edges < TAG_WAIT)
        begin
            if (disturb && edges == 4)
            begin
                check_flag("busy", busy, 1'b1);
                {block_valid, key_load, clear} = 3'b111;
                key = ~model_h;
                block = ~x;
            end
            next_cycle();
            edges++;
            {block_valid, key_load, clear} = 3'b000;
        end
        if (!tag_valid)
        begin
            errors++;
            $display("tag_valid did not arrive within %0d cycles of the block", TAG_WAIT);
        end
        else
        begin
            check_timing(edges + 1);
            check_tag("tag", tag, expected);
        end
        model_y = expected;
        // Tag pulse over, engine idle again.
        next_cycle();
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic single_block();
        load_key(rand_block());
        clear_hash();
        absorb_block(rand_block(), 1'b0);
    endtask

    task automatic chained_blocks();
        repeat (8) absorb_block(rand_block(), 1'b0);
    endtask

    task automatic special_operands();
        gf128_pkg::gf128_t x;
        x = rand_block();
        // H = x^0 gives the block back.
        load_key({1'b1, 127'h0});
        clear_hash();
        absorb_block(x, 1'b0);
        check_tag("tag", tag, x);
        absorb_block(x, 1'b0);
        check_tag("tag", tag, '0);
        // H = x^127, every term spills into the fold.
        load_key(128'h1);
        absorb_block({128{1'b1}}, 1'b0);
    endtask

    task automatic clear_and_rekey();
        repeat (2) absorb_block(rand_block(), 1'b0);
        clear_hash();
        absorb_block(rand_block(), 1'b0);
        load_key(rand_block());
        repeat (2) absorb_block(rand_block(), 1'b0);
    endtask

    task automatic dropped_strobes();
        absorb_block(rand_block(), 1'b1);
        // Key and Y must be the undisturbed ones.
        absorb_block(rand_block(), 1'b0);
    endtask

    task automatic reset_mid_multiply();
        block = rand_block();
        block_valid = 1'b1;
        next_cycle();
        block_valid = 1'b0;
        repeat (8) next_cycle();
        check_flag("busy", busy, 1'b1);
        apply_reset();
        check_flag("busy", busy, 1'b0);
        check_flag("tag_valid", tag_valid, 1'b0);
        // Zero key.
        absorb_block(rand_block(), 1'b0);
        check_tag("tag", tag, '0);
        load_key(rand_block());
        absorb_block(rand_block(), 1'b0);
    endtask

    initial
    begin
        rst = 1'b1;
        clear = 1'b0;
        key_load = 1'b0;
        block_valid = 1'b0;
        key = '0;
        block = '0;
        apply_reset();
        single_block();
        chained_blocks();
        special_operands();
        clear_and_rekey();
        dropped_strobes();
        reset_mid_multiply();
        $display("errors: %0d, assertion failures: %0d", errors, u_dut.u_asserts.assert_errors);
        if (errors == 0 && u_dut.u_asserts.assert_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- tests/ghash_asserts.sv
// Concurrent protocol checks on the GHASH top level, bound into every ghash_top.
`timescale 1ns/1ps

module ghash_asserts
(
    input logic clock,
    input logic rst,
    input logic busy,
    input logic tag_valid,
    input logic start,
    input logic done
);

    // Failed assertions, for the end-of-run summary.
    int assert_errors = 0;

    function automatic void flag_failure(string what);
        assert_errors++;
        $error("assertion failed: %s", what);
    endfunction

    // Tag is a one cycle pulse.
    a_tag_pulse: assert property (@(posedge clock) disable iff (rst) tag_valid |=> !tag_valid)
        else flag_failure("tag_valid high for two cycles");

    // Busy window ends with the tag.
    // Start, multiply and commit after the first busy cycle.
    a_tag_busy: assert property (@(posedge clock) disable iff (rst)
        $rose(busy) |-> ##(ghash_ctrl_pkg::MULT_LATENCY + 1) (busy && tag_valid))
        else flag_failure("busy window did not end with tag_valid");

    // Quiet after a reset edge.
    a_reset_quiet: assert property (@(posedge clock)
        rst |=> !busy && !tag_valid && !start && !done)
        else flag_failure("outputs not idle after reset");

    // Load edge plus one edge per digit.
    a_mult_latency: assert property (@(posedge clock) disable iff (rst)
        start |-> ##(ghash_ctrl_pkg::MULT_LATENCY) done)
        else flag_failure("done did not follow start by the multiply latency");

endmodule

bind ghash_top ghash_asserts u_asserts
(
    .clock     (clock),
    .rst       (rst),
    .busy      (busy),
    .tag_valid (tag_valid),
    .start     (mult_bus.start),
    .done      (mult_bus.done)
);

//--- hdl/ghash_top.sv
// GHASH engine top level, joining the core and the digit-serial multiplier.
`timescale 1ns/1ps

module ghash_top
(
    input  logic              clock,
    input  logic              rst,
    input  logic              clear,
    input  logic              key_load,
    input  gf128_pkg::gf128_t key,
    input  logic              block_valid,
    input  gf128_pkg::gf128_t block,
    output logic              busy,
    output logic              tag_valid,
    output gf128_pkg::gf128_t tag
);

    // Multiply request and result.
    gf_mult_if mult_bus ();

    // Sequencing and Y/H storage.
    ghash_core u_core
    (
        .clock       (clock),
        .rst         (rst),
        .clear       (clear),
        .key_load    (key_load),
        .key         (key),
        .block_valid (block_valid),
        .block       (block),
        .busy        (busy),
        .tag_valid   (tag_valid),
        .tag         (tag),
        .mult        (mult_bus.requester)
    );

    // Field multiplier.
    gf_2to128_multiplier_digit_serial u_mult
    (
        .clock (clock),
        .rst   (rst),
        .mult  (mult_bus.responder)
    );

endmodule

//--- hdl/ghash_core.sv
// GHASH sequencing: key and accumulator registers, block acceptance and tag output.
`timescale 1ns/1ps

module ghash_core
(
    input  logic              clock,
    input  logic              rst,
    input  logic              clear,
    input  logic              key_load,
    input  gf128_pkg::gf128_t key,
    input  logic              block_valid,
    input  gf128_pkg::gf128_t block,
    output logic              busy,
    output logic              tag_valid,
    output gf128_pkg::gf128_t tag,
    gf_mult_if.requester      mult
);

    ghash_ctrl_pkg::ghash_state_t state;

    // Hash subkey.
    gf128_pkg::gf128_t h_key;

    // Running hash Y.
    gf128_pkg::gf128_t y_acc;

    // Y as seen by a block arriving with clear.
    gf128_pkg::gf128_t y_base;

    // Multiplier operand, Y xor X.
    gf128_pkg::gf128_t op_b_q;

    logic start_q;
    logic accept;

    // A same-cycle clear hashes the block from Y = 0.
    assign y_base = clear ? '0 : y_acc;

    // Strobes count only in IDLE.
    assign accept = (state == ghash_ctrl_pkg::IDLE) && block_valid;

    // FSM, key and accumulator.
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state   <= ghash_ctrl_pkg::IDLE;
            start_q <= 1'b0;
            h_key   <= '0;
            y_acc   <= '0;
        end
        else
        begin
            // Start is a single cycle pulse.
            start_q <= 1'b0;
            case (state)
                ghash_ctrl_pkg::IDLE:
                begin
                    if (key_load)
                    begin
                        h_key <= key;
                    end
                    if (clear)
                    begin
                        y_acc <= '0;
                    end
                    if (block_valid)
                    begin
                        start_q <= 1'b1;
                        state   <= ghash_ctrl_pkg::MULT;
                    end
                end
                ghash_ctrl_pkg::MULT:
                begin
                    // Product lands MULT_LATENCY edges after start.
                    if (mult.done)
                    begin
                        y_acc <= mult.product;
                        state <= ghash_ctrl_pkg::UPDATE;
                    end
                end
                ghash_ctrl_pkg::UPDATE:
                begin
                    // One cycle of tag_valid, then idle.
                    state <= ghash_ctrl_pkg::IDLE;
                end
                default:
                begin
                    state <= ghash_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    // Operand register.
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            op_b_q <= y_base ^ block;
        end
    end

    // H register already holds a same-cycle key_load when start is seen.
    assign mult.start = start_q;
    assign mult.op_a  = h_key;
    assign mult.op_b  = op_b_q;

    // Busy spans MULT and UPDATE.
    assign busy      = (state != ghash_ctrl_pkg::IDLE);
    assign tag_valid = (state == ghash_ctrl_pkg::UPDATE);
    assign tag       = y_acc;

endmodule

//--- hdl/gf_2to128_multiplier_digit_serial.sv
// Digit-serial GF(2^128) multiplier, Horner order, one eight bit digit of op_b per clock.
`timescale 1ns/1ps

module gf_2to128_multiplier_digit_serial
(
    input logic          clock,
    input logic          rst,
    gf_mult_if.responder mult
);

    // Operand registers.
    gf128_pkg::gf128_t a_reg;
    gf128_pkg::gf128_t b_reg;

    // Horner accumulator.
    gf128_pkg::gf128_t acc;

    // Reduction of the eight bits leaving the accumulator.
    gf128_pkg::gf128_t acc_fold;

    // op_a times current digit.
    gf128_pkg::gf128_t digit_prod;

    ghash_ctrl_pkg::step_cnt_t step_cnt;
    logic running;
    logic done_q;
    logic accept;
    logic last_step;

    // Requests are ignored while a product is in flight.
    assign accept = mult.start && !running;

    assign last_step = running
        && (step_cnt == ghash_ctrl_pkg::step_cnt_t'(gf128_pkg::N_STEPS - 1));

    // Accumulator bits 7..0 are x^120..x^127.
    // After times x^8 they sit at x^128..x^135, MSB first.
    gf_2to128_multiplier_booth1_subrem
    #(
        .N_SUBPROD (gf128_pkg::NB_DIGIT),
        .NB_DATA   (gf128_pkg::NB_GF)
    )
    u_acc_fold
    (
        .sub_remainder (acc_fold),
        .data          (acc[gf128_pkg::NB_DIGIT-1:0])
    );

    // Current digit is always the low byte of b_reg.
    // Low vector bits are the highest degree terms, consumed first.
    gf_2to128_digit_product u_digit
    (
        .element (a_reg),
        .digit   (b_reg[gf128_pkg::NB_DIGIT-1:0]),
        .product (digit_prod)
    );

    // Step counter, run flag and done pulse.
    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            running  <= 1'b0;
            step_cnt <= '0;
            done_q   <= 1'b0;
        end
        else
        begin
            // Done follows the last step by one edge.
            done_q <= last_step;
            if (accept)
            begin
                running  <= 1'b1;
                step_cnt <= '0;
            end
            else if (running)
            begin
                step_cnt <= step_cnt + 1'b1;
                if (last_step)
                begin
                    running <= 1'b0;
                end
            end
        end
    end

    // Datapath.
    always_ff @(posedge clock)
    begin
        if (accept)
        begin
            // Load edge, no step yet.
            a_reg <= mult.op_a;
            b_reg <= mult.op_b;
            acc   <= '0;
        end
        else if (running)
        begin
            // acc = acc * x^8 + a * digit.
            acc   <= (acc >> gf128_pkg::NB_DIGIT) ^ acc_fold ^ digit_prod;
            // Next digit moves into the low byte.
            b_reg <= b_reg >> gf128_pkg::NB_DIGIT;
        end
    end

    assign mult.done    = done_q;
    // Accumulator holds the final product in the done cycle.
    assign mult.product = acc;

endmodule

//--- hdl/gf_2to128_digit_product.sv
// Combinational product of a field element and one eight bit digit, with reduction.
`timescale 1ns/1ps

module gf_2to128_digit_product
(
    input  gf128_pkg::gf128_t    element,
    input  gf128_pkg::gf_digit_t digit,
    output gf128_pkg::gf128_t    product
);

    // Unreduced sum, element bits on top and overflow terms below.
    // Bit NB_DIGIT-2 is the x^128 coefficient, bit 0 the x^134 one.
    logic [gf128_pkg::NB_GF+gf128_pkg::NB_DIGIT-2:0] sum_wide;

    // Terms past x^127.
    logic [gf128_pkg::NB_DIGIT-2:0] overflow;

    // Reduction of the overflow terms.
    gf128_pkg::gf128_t fold;

    // Shift and add over the digit bits.
    // Digit MSB is x^0, so digit bit 7-j selects element times x^j.
    // Multiplying by x^j is a right shift in GCM order.
    always_comb
    begin
        sum_wide = '0;
        for (int j = 0; j < gf128_pkg::NB_DIGIT; j++)
        begin
            if (digit[gf128_pkg::NB_DIGIT-1-j])
            begin
                sum_wide = sum_wide
                    ^ ({element, {(gf128_pkg::NB_DIGIT-1){1'b0}}} >> j);
            end
        end
    end

    // Low bits of the wide sum fell off the x^127 end.
    assign overflow = sum_wide[gf128_pkg::NB_DIGIT-2:0];

    // Fold seven overflow terms.
    gf_2to128_multiplier_booth1_subrem
    #(
        .N_SUBPROD (gf128_pkg::NB_DIGIT - 1),
        .NB_DATA   (gf128_pkg::NB_GF)
    )
    u_fold
    (
        .sub_remainder (fold),
        .data          (overflow)
    );

    // In-field part plus folded remainder.
    assign product = sum_wide[gf128_pkg::NB_GF+gf128_pkg::NB_DIGIT-2:gf128_pkg::NB_DIGIT-1]
        ^ fold;

endmodule

//--- hdl/gf_2to128_multiplier_booth1_subrem.sv
// Folds bits beyond x^127 back into the field by summing shifted copies of the reduction constant.
`timescale 1ns/1ps

module gf_2to128_multiplier_booth1_subrem
#(
    parameter int N_SUBPROD = 1,
    parameter int NB_DATA   = 128
)
(
    output logic [NB_DATA-1:0]   sub_remainder,
    input  logic [N_SUBPROD-1:0] data
);

    // Only the 128 bit field is supported.
    localparam bit BAD_CONF = (NB_DATA != gf128_pkg::NB_GF);

    // One gated constant per overflow bit.
    logic [NB_DATA-1:0] gated [N_SUBPROD];

    if (BAD_CONF)
    begin : g_bad_conf
        $error("subrem supports only a 128 bit data width");
    end

    // MSB of data is the x^128 term, reduced by R itself.
    // Each lower bit is one degree higher, so R moves one place right.
    // Shifts stay below 8, so no copy spills past x^127 again.
    for (genvar i = 0; i < N_SUBPROD; i++)
    begin : g_gate
        assign gated[i] = {NB_DATA{data[N_SUBPROD-1-i]}} & (gf128_pkg::GF_R >> i);
    end

    // XOR tree over all gated copies.
    always_comb
    begin
        sub_remainder = '0;
        for (int k = 0; k < N_SUBPROD; k++)
        begin
            sub_remainder = sub_remainder ^ gated[k];
        end
    end

endmodule

//--- hdl/gf_mult_if.sv
// Request and result bus between the GHASH core and the field multiplier.
`timescale 1ns/1ps

interface gf_mult_if;

    // One cycle request pulse.
    logic start;

    // Hash subkey H.
    gf128_pkg::gf128_t op_a;

    // Operand, normally Y xor X.
    gf128_pkg::gf128_t op_b;

    // One cycle completion pulse.
    logic done;

    // Result, valid only while done is high.
    gf128_pkg::gf128_t product;

    // Core side.
    modport requester
    (
        output start,
        output op_a,
        output op_b,
        input  done,
        input  product
    );

    // Multiplier side.
    modport responder
    (
        input  start,
        input  op_a,
        input  op_b,
        output done,
        output product
    );

endinterface

//--- hdl/ghash_ctrl_pkg.sv
// Control types and latency constant for the GHASH sequencing logic and its checks.
package ghash_ctrl_pkg;

    // Counts the digit steps of one product.
    // Width follows the number of steps in the field package.
    typedef logic [$clog2(gf128_pkg::N_STEPS)-1:0] step_cnt_t;

    // Core FSM states.
    typedef enum logic [1:0]
    {
        IDLE,
        MULT,
        UPDATE
    } ghash_state_t;

    // Edges from the one that samples start to the one that samples done.
    // One load edge plus one edge per digit step.
    localparam int MULT_LATENCY = gf128_pkg::N_STEPS + 1;

endpackage

//--- hdl/gf128_pkg.sv
// GF(2^128) field widths, element types and reduction constant shared by all datapath blocks.
package gf128_pkg;

    // Field element width.
    localparam int NB_GF = 128;

    // Operand bits consumed per multiplier step.
    localparam int NB_DIGIT = 8;

    // Steps per full product.
    localparam int N_STEPS = NB_GF / NB_DIGIT;

    // Field element in GCM bit order.
    // Bit 127 holds the x^0 coefficient, bit 0 holds x^127.
    typedef logic [NB_GF-1:0] gf128_t;

    // One operand digit, same bit order as the element.
    // Bit 7 is the lowest degree term of the digit.
    typedef logic [NB_DIGIT-1:0] gf_digit_t;

    // Reduction constant for x^128 = 1 + x + x^2 + x^7.
    // Written as 0xE1 in the top byte because of the reflected order.
    localparam gf128_t GF_R = {8'he1, {(NB_GF-8){1'b0}}};

endpackage
